// ==== tb.f ====
src/ifu_pkg.sv
src/icache_fill_if.sv
src/ifu_beat_counter.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/ifu_fetch_fsm.sv
src/ifu_top.sv
verif/ifu_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch unit testbench, exit status follows the simulation
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f tb.f --top-module ifu_top_tb -o sim_ifu \
  && ./obj_dir/sim_ifu \
  || { echo "simulation failed"; exit 1; }

// ==== verif/ifu_top_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ifu_top_tb;

  localparam int NUM_SETS       = 8;
  localparam int LINE_WORDS     = 2;
  localparam int LINE_BYTES     = LINE_WORDS * 4;
  localparam int SET_W          = $clog2(NUM_SETS);
  localparam int NUM_FETCHES    = 300;
  localparam int TIMEOUT_CYCLES = 8000;

  // pcs stay in a 512 byte window, eight tags compete for each set
  localparam ifu_pkg::addr_t REGION_MASK = 32'h0000_01fc;

  logic           clk;
  logic           rst;
  logic           prev_valid_i;
  ifu_pkg::addr_t pc_i;
  logic           ready_o;
  logic           valid_o;
  logic           next_ready_i;
  ifu_pkg::word_t inst_o;
  ifu_pkg::addr_t pc_o;
  ifu_pkg::addr_t araddr_o;
  logic           arvalid_o;
  ifu_pkg::word_t rdata_i;
  logic           rvalid_i;

  // reference model and monitor state
  logic [NUM_SETS-1:0] model_valid;
  ifu_pkg::addr_t      model_line [NUM_SETS];
  ifu_pkg::addr_t      acc_pc;
  logic                expect_hit;
  logic                seen_arvalid;
  logic                fence_pending;
  // valid bits as they were just before the last fence.i
  logic [NUM_SETS-1:0] stale_valid;
  logic                refetch_cached;
  int                  exp_beat;
  logic                held;
  ifu_pkg::word_t      held_inst;
  ifu_pkg::addr_t      held_pc;
  int                  hit_cnt = 0;
  int                  miss_cnt = 0;
  int                  fence_cnt = 0;
  int                  refetch_cnt = 0;
  int                  stall_cnt = 0;
  int                  cycle_cnt = 0;

  // memory responder
  logic busy;
  int   wait_cnt;

  ifu_pkg::addr_t history[$];
  ifu_pkg::addr_t next_pc;
  int             roll;

  ifu_top #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) UUT (
    .clk          (clk),
    .rst          (rst),
    .prev_valid_i (prev_valid_i),
    .pc_i         (pc_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .next_ready_i (next_ready_i),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .araddr_o     (araddr_o),
    .arvalid_o    (arvalid_o),
    .rdata_i      (rdata_i),
    .rvalid_i     (rvalid_i)
  );

  // memory contents, a hash of the address except at the fence.i slots
  function automatic ifu_pkg::word_t mem_word(input ifu_pkg::addr_t a);
    ifu_pkg::word_t w;
    if (a == 32'h0000_00bc || a == 32'h0000_016c || a == 32'h0000_01f0)
    begin
      return ifu_pkg::FENCE_I_INST;
    end
    w = (a * 32'h9e37_79b1) ^ (a >> 3) ^ 32'h5a5a_0f0f;
    if (w == ifu_pkg::FENCE_I_INST)
    begin
      w = ~w;
    end
    return w;
  endfunction

  function automatic ifu_pkg::addr_t line_base(input ifu_pkg::addr_t a);
    return a & ~ifu_pkg::addr_t'(LINE_BYTES - 1);
  endfunction

  function automatic logic [SET_W-1:0] set_of(input ifu_pkg::addr_t a);
    return SET_W'(a / LINE_BYTES);
  endfunction

  task automatic stop_failed();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAILED %s expected %h got %h", name, exp, got);
    stop_failed();
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    stop_failed();
  endtask

  // offer one pc upstream, then wait until downstream takes the instruction
  task automatic fetch_one(input ifu_pkg::addr_t pc);
    prev_valid_i <= 1'b1;
    pc_i         <= pc;
    @(posedge clk);
    while (!ready_o)
    begin
      @(posedge clk);
    end
    prev_valid_i <= 1'b0;
    @(posedge clk);
    while (!(valid_o && next_ready_i))
    begin
      @(posedge clk);
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      abort_run("timeout, fetch sequence did not finish within the cycle limit");
    end
  end

  // downstream stalls about a quarter of the time
  always @(posedge clk)
  begin
    if (rst)
    begin
      next_ready_i <= 1'b0;
    end
    else
    begin
      next_ready_i <= ($urandom_range(3, 0) != 0);
    end
  end

  // one response per request, 1 to 4 cycles after it is seen
  always @(posedge clk)
  begin
    if (rst)
    begin
      rvalid_i <= 1'b0;
      busy     <= 1'b0;
      wait_cnt <= 0;
    end
    else
    begin
      rvalid_i <= 1'b0;
      if (busy)
      begin
        if (wait_cnt == 1)
        begin
          rvalid_i <= 1'b1;
          rdata_i  <= mem_word(araddr_o);
          busy     <= 1'b0;
        end
        else
        begin
          wait_cnt <= wait_cnt - 1;
        end
      end
      else if (arvalid_o && !rvalid_i)
      begin
        busy     <= 1'b1;
        wait_cnt <= $urandom_range(4, 1);
      end
    end
  end

  // reference model, follows the handshakes seen at each edge
  always @(posedge clk)
  begin
    if (rst)
    begin
      model_valid    <= '0;
      stale_valid    <= '0;
      seen_arvalid   <= 1'b0;
      expect_hit     <= 1'b0;
      fence_pending  <= 1'b0;
      refetch_cached <= 1'b0;
      exp_beat       <= 0;
      held           <= 1'b0;
    end
    else
    begin
      if (prev_valid_i && ready_o)
      begin
        acc_pc         <= pc_i;
        expect_hit     <= model_valid[set_of(pc_i)] &&
                          (model_line[set_of(pc_i)] == line_base(pc_i));
        // tags survive the flush, only the valid bits are dropped
        refetch_cached <= fence_pending && stale_valid[set_of(pc_i)] &&
                          (model_line[set_of(pc_i)] == line_base(pc_i));
        seen_arvalid   <= 1'b0;
        exp_beat       <= 0;
        fence_pending  <= 1'b0;
      end
      if (arvalid_o)
      begin
        seen_arvalid <= 1'b1;
      end
      if (arvalid_o && rvalid_i)
      begin
        exp_beat <= exp_beat + 1;
        if (exp_beat == LINE_WORDS - 1)
        begin
          model_valid[set_of(acc_pc)] <= 1'b1;
          model_line[set_of(acc_pc)]  <= line_base(acc_pc);
        end
      end
      if (valid_o && next_ready_i)
      begin
        if (expect_hit)
          hit_cnt <= hit_cnt + 1;
        else
          miss_cnt <= miss_cnt + 1;
        if (refetch_cached)
          refetch_cnt <= refetch_cnt + 1;
        // fence.i empties the whole cache
        if (mem_word(acc_pc) == ifu_pkg::FENCE_I_INST)
        begin
          stale_valid   <= model_valid;
          model_valid   <= '0;
          fence_pending <= 1'b1;
          fence_cnt     <= fence_cnt + 1;
        end
      end
      held      <= valid_o && !next_ready_i;
      held_inst <= inst_o;
      held_pc   <= pc_o;
      if (valid_o && !next_ready_i)
        stall_cnt <= stall_cnt + 1;
    end
  end

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (valid_o)
      begin
        assert (pc_o == acc_pc) else report_mismatch("pc_o", acc_pc, pc_o);
        assert (inst_o == mem_word(pc_o))
          else report_mismatch("inst_o", mem_word(pc_o), inst_o);
        // a line cached before fence.i must be fetched again
        if (refetch_cached)
        begin
          assert (seen_arvalid)
            else abort_run("line cached before fence.i was served as a hit");
        end
        assert (seen_arvalid == !expect_hit)
          else abort_run("hit or miss of the fetch differs from the reference cache");
      end
      if (arvalid_o)
      begin
        assert (exp_beat < LINE_WORDS) else abort_run("refill ran past the end of the line");
        assert (araddr_o == line_base(acc_pc) + ifu_pkg::addr_t'(exp_beat * 4))
          else report_mismatch("araddr_o", line_base(acc_pc) + ifu_pkg::addr_t'(exp_beat * 4),
                               araddr_o);
      end
      // outputs frozen while downstream stalls
      if (held)
      begin
        assert (valid_o) else report_mismatch("valid_o", 32'h1, 32'(valid_o));
        assert (inst_o == held_inst) else report_mismatch("inst_o", held_inst, inst_o);
        assert (pc_o == held_pc) else report_mismatch("pc_o", held_pc, pc_o);
      end
    end
  end

  initial
  begin
    rst          = 1'b1;
    prev_valid_i = 1'b0;
    pc_i         = '0;
    next_ready_i = 1'b0;
    rdata_i      = '0;
    rvalid_i     = 1'b0;
    void'($urandom(32'hd975));
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (ready_o) else report_mismatch("ready_o", 32'h1, 32'(ready_o));
    assert (!valid_o) else report_mismatch("valid_o", 32'h0, 32'(valid_o));
    assert (!arvalid_o) else report_mismatch("arvalid_o", 32'h0, 32'(arvalid_o));

    next_pc = '0;
    for (int n = 0; n < NUM_FETCHES; n++)
    begin
      roll = $urandom_range(15, 0);
      if (n % 50 == 25)
      begin
        // make sure the fence.i slots are reached
        case ((n / 50) % 3)
          0: next_pc = 32'h0000_00bc;
          1: next_pc = 32'h0000_016c;
          default: next_pc = 32'h0000_01f0;
        endcase
      end
      else if (n % 50 == 26)
        // step on from the fence.i, 0x1f4 shares the flushed line of 0x1f0
        next_pc = (next_pc + 32'd4) & REGION_MASK;
      else if (roll == 0)
        next_pc = ifu_pkg::addr_t'($urandom_range(127, 0)) << 2;
      else if (roll == 1 && history.size() > 0)
        next_pc = history[$urandom_range(history.size() - 1, 0)];
      else if (n > 0)
        next_pc = (next_pc + 32'd4) & REGION_MASK;
      history.push_back(next_pc);
      if (history.size() > 16)
        void'(history.pop_front());
      if ($urandom_range(3, 0) == 0)
        @(posedge clk);
      fetch_one(next_pc);
    end
    repeat (4) @(posedge clk);

    if (hit_cnt == 0 || miss_cnt == 0 || fence_cnt == 0 || refetch_cnt == 0 ||
        stall_cnt == 0)
    begin
      abort_run("stimulus never produced a hit, a miss, a fence.i, a refetch and a stall");
    end
    else
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== src/ifu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ifu_top #(
  parameter int NUM_SETS   = 8,
  parameter int LINE_WORDS = 2
) (
  input  wire            clk,
  input  wire            rst,

  input  wire            prev_valid_i,
  input  ifu_pkg::addr_t pc_i,
  output logic           ready_o,

  output logic           valid_o,
  input  wire            next_ready_i,
  output ifu_pkg::word_t inst_o,
  output ifu_pkg::addr_t pc_o,

  output ifu_pkg::addr_t araddr_o,
  output logic           arvalid_o,
  input  ifu_pkg::word_t rdata_i,
  input  wire            rvalid_i
);

  localparam int OFF_W = $clog2(LINE_WORDS);

  logic             hit;
  ifu_pkg::word_t   rd_word;
  logic             inval;
  logic             beat_clr;
  logic             beat_inc;
  logic [OFF_W-1:0] beat;
  logic             beat_last;

  icache_fill_if #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) fill_bus ();

  ifu_fetch_fsm #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_fsm (
    .clk          (clk),
    .rst          (rst),
    .prev_valid_i (prev_valid_i),
    .pc_i         (pc_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .next_ready_i (next_ready_i),
    .pc_o         (pc_o),
    .inst_o       (inst_o),
    .hit_i        (hit),
    .rd_word_i    (rd_word),
    .araddr_o     (araddr_o),
    .arvalid_o    (arvalid_o),
    .rdata_i      (rdata_i),
    .rvalid_i     (rvalid_i),
    .beat_i       (beat),
    .beat_last_i  (beat_last),
    .beat_clr_o   (beat_clr),
    .beat_inc_o   (beat_inc),
    .inval_o      (inval),
    .fill         (fill_bus.fsm)
  );

  ifu_beat_counter #(
    .LINE_WORDS (LINE_WORDS)
  ) u_beat (
    .clk    (clk),
    .rst    (rst),
    .clr_i  (beat_clr),
    .inc_i  (beat_inc),
    .beat_o (beat),
    .last_o (beat_last)
  );

  // both arrays are indexed by the registered pc
  icache_tag_array #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_tags (
    .clk     (clk),
    .rst     (rst),
    .pc_i    (pc_o),
    .inval_i (inval),
    .hit_o   (hit),
    .fill    (fill_bus.tag)
  );

  icache_data_array #(
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_data (
    .clk       (clk),
    .pc_i      (pc_o),
    .rd_word_o (rd_word),
    .fill      (fill_bus.data)
  );

endmodule

`default_nettype wire

// ==== src/ifu_fetch_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module ifu_fetch_fsm #(
  parameter int NUM_SETS   = 8,
  parameter int LINE_WORDS = 2
) (
  input  wire                  clk,
  input  wire                  rst,

  // upstream pc
  input  wire                  prev_valid_i,
  input  ifu_pkg::addr_t       pc_i,
  output logic                 ready_o,

  // downstream instruction
  output logic                 valid_o,
  input  wire                  next_ready_i,
  output ifu_pkg::addr_t       pc_o,
  output ifu_pkg::word_t       inst_o,

  // cache lookup results
  input  wire                  hit_i,
  input  ifu_pkg::word_t       rd_word_i,

  // read bus
  output ifu_pkg::addr_t       araddr_o,
  output logic                 arvalid_o,
  input  ifu_pkg::word_t       rdata_i,
  input  wire                  rvalid_i,

  // beat counter
  input  wire [$clog2(LINE_WORDS)-1:0] beat_i,
  input  wire                  beat_last_i,
  output logic                 beat_clr_o,
  output logic                 beat_inc_o,

  output logic                 inval_o,
  icache_fill_if.fsm           fill
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

  ifu_pkg::fetch_state_e state_q;
  ifu_pkg::fetch_state_e state_d;
  ifu_pkg::addr_t        pc_q;

  logic [IDX_W-1:0] pc_idx;
  logic [TAG_W-1:0] pc_tag;
  logic             take_pc;
  logic             inst_taken;
  logic             beat_done;

  assign pc_idx = pc_q[IDX_W+OFF_W+1:OFF_W+2];
  assign pc_tag = pc_q[31:IDX_W+OFF_W+2];

  assign ready_o   = (state_q == ifu_pkg::S_IDLE);
  assign valid_o   = (state_q == ifu_pkg::S_LOOKUP) && hit_i;
  assign arvalid_o = (state_q == ifu_pkg::S_REFILL);
  assign inval_o   = (state_q == ifu_pkg::S_INVAL);

  assign take_pc    = ready_o && prev_valid_i;
  assign inst_taken = valid_o && next_ready_i;
  assign beat_done  = arvalid_o && rvalid_i;

  // pc_q and the array contents are frozen while waiting on next_ready_i
  assign pc_o   = pc_q;
  assign inst_o = rd_word_i;

  // word address inside the missing line
  assign araddr_o = {pc_q[31:OFF_W+2], beat_i, 2'b00};

  // counter restarts on the miss, steps on every returned word
  assign beat_clr_o = (state_q == ifu_pkg::S_LOOKUP) && !hit_i;
  assign beat_inc_o = beat_done;

  assign fill.fill_we     = beat_done;
  assign fill.fill_idx    = pc_idx;
  assign fill.fill_word   = beat_i;
  assign fill.fill_data   = rdata_i;
  assign fill.fill_commit = beat_done && beat_last_i;
  assign fill.fill_tag    = pc_tag;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ifu_pkg::S_IDLE:
      begin
        if (take_pc)
        begin
          state_d = ifu_pkg::S_LOOKUP;
        end
      end
      ifu_pkg::S_LOOKUP:
      begin
        if (!hit_i)
        begin
          state_d = ifu_pkg::S_REFILL;
        end
        else if (inst_taken)
        begin
          // fence.i flushes the whole cache before the next fetch
          if (rd_word_i == ifu_pkg::FENCE_I_INST)
          begin
            state_d = ifu_pkg::S_INVAL;
          end
          else
          begin
            state_d = ifu_pkg::S_IDLE;
          end
        end
      end
      ifu_pkg::S_REFILL:
      begin
        if (beat_done && beat_last_i)
        begin
          state_d = ifu_pkg::S_LOOKUP;
        end
      end
      default:
      begin
        state_d = ifu_pkg::S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= ifu_pkg::S_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take_pc)
    begin
      pc_q <= pc_i;
    end
  end

  // an instruction is never offered while the bus is busy
  assert property (@(posedge clk) disable iff (rst) !(valid_o && arvalid_o))
    else $error("ifu_fetch_fsm: valid_o and arvalid_o both high");

  // memory must not answer unless a refill is running
  assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> (state_q == ifu_pkg::S_REFILL))
    else $error("ifu_fetch_fsm: rvalid_i outside refill, state %0d", state_q);

endmodule

`default_nettype wire

// ==== src/icache_data_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_data_array #(
  parameter int NUM_SETS   = 8,
  parameter int LINE_WORDS = 2
) (
  input  wire            clk,
  input  ifu_pkg::addr_t pc_i,
  output ifu_pkg::word_t rd_word_o,
  icache_fill_if.data    fill
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int OFF_W = $clog2(LINE_WORDS);

  // flat storage, line index in the upper bits
  ifu_pkg::word_t mem [NUM_SETS*LINE_WORDS];

  logic [IDX_W+OFF_W-1:0] wr_addr;
  logic [IDX_W+OFF_W-1:0] rd_addr;

  assign wr_addr = {fill.fill_idx, fill.fill_word};
  assign rd_addr = pc_i[IDX_W+OFF_W+1:2];

  always_ff @(posedge clk)
  begin
    if (fill.fill_we)
    begin
      mem[wr_addr] <= fill.fill_data;
    end
  end

  // asynchronous read, the hit check runs in the same cycle
  assign rd_word_o = mem[rd_addr];

endmodule

`default_nettype wire

// ==== src/icache_tag_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array #(
  parameter int NUM_SETS   = 8,
  parameter int LINE_WORDS = 2
) (
  input  wire            clk,
  input  wire            rst,
  input  ifu_pkg::addr_t pc_i,
  input  wire            inval_i,
  output logic           hit_o,
  icache_fill_if.tag     fill
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

  logic [NUM_SETS-1:0] valid_q;
  logic [TAG_W-1:0]    tag_mem [NUM_SETS];

  logic [IDX_W-1:0] lk_idx;
  logic [TAG_W-1:0] lk_tag;

  assign lk_idx = pc_i[IDX_W+OFF_W+1:OFF_W+2];
  assign lk_tag = pc_i[31:IDX_W+OFF_W+2];

  // valid bits
  always_ff @(posedge clk)
  begin
    if (rst || inval_i)
    begin
      valid_q <= '0;
    end
    else if (fill.fill_commit)
    begin
      valid_q[fill.fill_idx] <= 1'b1;
    end
  end

  // tag storage, only meaningful where valid
  always_ff @(posedge clk)
  begin
    if (fill.fill_commit)
    begin
      tag_mem[fill.fill_idx] <= fill.fill_tag;
    end
  end

  assign hit_o = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);

  // flush and refill never overlap, S_INVAL and S_REFILL are distinct
  assert property (@(posedge clk) disable iff (rst) !(inval_i && fill.fill_commit))
    else $error("icache_tag_array: inval_i with commit to line %0d", fill.fill_idx);

endmodule

`default_nettype wire

// ==== src/ifu_beat_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module ifu_beat_counter #(
  parameter int LINE_WORDS = 2
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          clr_i,
  input  wire                          inc_i,
  output logic [$clog2(LINE_WORDS)-1:0] beat_o,
  output logic                         last_o
);

  localparam int OFF_W = $clog2(LINE_WORDS);

  logic [OFF_W-1:0] beat_q;

  always_ff @(posedge clk)
  begin
    if (rst || clr_i)
    begin
      beat_q <= '0;
    end
    else if (inc_i)
    begin
      // wraps back to zero after the last word
      beat_q <= beat_q + 1'b1;
    end
  end

  assign beat_o = beat_q;
  assign last_o = (beat_q == OFF_W'(LINE_WORDS - 1));

  // clear comes from lookup, increment only from refill
  assert property (@(posedge clk) disable iff (rst) !(clr_i && inc_i))
    else $error("ifu_beat_counter: clr_i and inc_i together, beat %0d", beat_q);

endmodule

`default_nettype wire

// ==== src/icache_fill_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface icache_fill_if #(
  parameter int NUM_SETS   = 8,
  parameter int LINE_WORDS = 2
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

  // per-beat word write
  logic                 fill_we;
  logic [IDX_W-1:0]     fill_idx;
  logic [OFF_W-1:0]     fill_word;
  ifu_pkg::word_t       fill_data;

  // line completion
  logic                 fill_commit;
  logic [TAG_W-1:0]     fill_tag;

  modport fsm (
    output fill_we, fill_idx, fill_word, fill_data, fill_commit, fill_tag
  );

  modport data (input fill_we, fill_idx, fill_word, fill_data);

  modport tag (input fill_commit, fill_idx, fill_tag);

endinterface

`default_nettype wire

// ==== src/ifu_pkg.sv ====
`default_nettype none

package ifu_pkg;

  // raw instruction or bus data
  typedef logic [31:0] word_t;

  // byte address, word aligned for fetch
  typedef logic [31:0] addr_t;

  // fence.i, funct3=001 in the MISC-MEM opcode
  localparam word_t FENCE_I_INST = 32'h0000100f;

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOKUP,
    S_REFILL,
    S_INVAL
  } fetch_state_e;

endpackage

`default_nettype wire
